//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_uart_rx
FILELIST = sources.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = RESULT: PASS

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- source/rx_fifo.sv
`timescale 1ns/10ps

module rx_fifo (
	input  logic                clk,
	input  logic                nrst,
	input  uart_pkg::rx_frame_t push_frame,
	input  logic                push,        // no back-pressure, always taken
	input  logic                pop,
	input  logic                overrun_clr,
	output uart_pkg::rx_frame_t head,        // oldest entry, valid when !empty
	output logic                empty,
	output logic                full,
	output logic                overrun      // sticky
);

	// --------------------
	// storage and pointers
	// --------------------

	uart_pkg::rx_frame_t mem [uart_pkg::FIFO_DEPTH];

	logic [uart_pkg::FIFO_AW-1:0] wr_ptr;
	logic [uart_pkg::FIFO_AW-1:0] rd_ptr;
	logic [uart_pkg::FIFO_AW:0]   count;  // one extra bit so full fits
	logic                         do_push;
	logic                         do_pop;

	assign do_push = push & ~full;  // push while full is lost
	assign do_pop  = pop & ~empty;  // pop while empty does nothing

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= push_frame;
	end

	always_ff @(posedge clk) begin
		if (!nrst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1; // depth is a power of two, wraps by itself
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
		end
	end

	// --------------------
	// overrun flag
	// --------------------

	always_ff @(posedge clk) begin
		if (!nrst)
			overrun <= 1'b0;
		else if (push && full)
			overrun <= 1'b1; // a new drop wins over a clear in the same cycle
		else if (overrun_clr)
			overrun <= 1'b0;
	end

	assign head  = mem[rd_ptr];
	assign empty = (count == '0);
	assign full  = (count == (uart_pkg::FIFO_AW + 1)'(uart_pkg::FIFO_DEPTH));

endmodule

//--- source/uart_pkg.sv
package uart_pkg;

	// --------------------
	// serial bit timing
	// --------------------

	localparam int BIT_CLKS      = 16;           // clk cycles per serial bit
	localparam int HALF_BIT_CLKS = BIT_CLKS / 2; // offset from bit edge to bit centre

	// sample counter has to hold the 1.5 bit reload after the start edge
	localparam int RX_CNT_W = $clog2(BIT_CLKS + HALF_BIT_CLKS);

	// --------------------
	// receive fifo
	// --------------------

	localparam int FIFO_DEPTH = 8; // frames held
	localparam int FIFO_AW    = 3; // log2 of FIFO_DEPTH, pointers wrap on their own

	// --------------------
	// status register bits
	// --------------------

	localparam int STAT_EMPTY = 0; // fifo has nothing to read
	localparam int STAT_FULL  = 1; // fifo holds FIFO_DEPTH frames
	localparam int STAT_FERR  = 2; // head frame had a low stop bit
	localparam int STAT_OVR   = 3; // sticky, a frame was dropped while full
	localparam int STAT_BUSY  = 4; // receiver is inside a frame

	// --------------------
	// types
	// --------------------

	// one received character plus its framing result
	typedef struct packed {
		logic [7:0] data;      // lsb was first on the line
		logic       frame_err; // stop bit sampled low
	} rx_frame_t;

	// host side of the wishbone classic bus
	typedef struct packed {
		logic       cyc;
		logic       stb;
		logic       we;
		logic [1:0] adr;   // register index, not a byte address
		logic [7:0] dat_w;
	} wb_req_t;

	// slave side of the bus
	typedef struct packed {
		logic       ack;
		logic [7:0] dat_r;
	} wb_rsp_t;

	// register map, index 3 is unused and reads 0
	typedef enum logic [1:0] {
		REG_DATA   = 2'd0, // read pops the fifo
		REG_STATUS = 2'd1, // flag bits, see STAT_*
		REG_CTRL   = 2'd2  // write only, bit3 clears overrun
	} wb_reg_e;

	typedef enum logic [1:0] {
		RX_IDLE = 2'd0, // waiting for a falling edge
		RX_DATA = 2'd1, // sampling the eight data bits
		RX_STOP = 2'd2  // waiting for the stop bit centre
	} rx_state_e;

endpackage

//--- source/uart_receiver.sv
`timescale 1ns/10ps

module uart_receiver (
	input  logic                clk,
	input  logic                nrst,
	input  logic                rxd,         // async serial in, idles high
	output uart_pkg::rx_frame_t frame,       // valid only with frame_valid
	output logic                frame_valid, // one clk strobe at stop bit centre
	output logic                rx_busy
);

	// --------------------
	// input synchronizer
	// --------------------

	logic rxd_meta; // first flop, may go metastable
	logic rxd_sync; // second flop, safe to use
	logic rxd_prev; // rxd_sync one clk later, for edge detect
	logic start_edge;

	always_ff @(posedge clk) begin
		if (!nrst) begin
			// line idles high, so preset to 1 to avoid a false start edge
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
			rxd_prev <= 1'b1;
		end else begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
			rxd_prev <= rxd_sync;
		end
	end

	assign start_edge = rxd_prev & ~rxd_sync; // high then low

	// --------------------
	// frame state machine
	// --------------------

	uart_pkg::rx_state_e            state;
	logic [uart_pkg::RX_CNT_W-1:0]  sample_cnt; // counts down to the next bit centre
	logic [2:0]                     bit_idx;    // data bit being sampled
	logic [7:0]                     shift_q;    // data bits, shifted in from the top
	logic                           sample_now;

	assign sample_now = (sample_cnt == '0);

	always_ff @(posedge clk) begin
		if (!nrst) begin
			state      <= uart_pkg::RX_IDLE;
			sample_cnt <= '0;
			bit_idx    <= '0;
		end else begin
			case (state)
				uart_pkg::RX_IDLE: begin
					if (start_edge) begin
						// skip the start bit and land in the middle of bit 0
						sample_cnt <= uart_pkg::RX_CNT_W'(uart_pkg::BIT_CLKS +
							uart_pkg::HALF_BIT_CLKS - 1);
						bit_idx    <= '0;
						state      <= uart_pkg::RX_DATA;
					end
				end
				uart_pkg::RX_DATA: begin
					if (sample_now) begin
						sample_cnt <= uart_pkg::RX_CNT_W'(uart_pkg::BIT_CLKS - 1);
						bit_idx    <= bit_idx + 3'd1;
						if (bit_idx == 3'd7)
							state <= uart_pkg::RX_STOP; // last data bit taken
					end else begin
						sample_cnt <= sample_cnt - 1'b1;
					end
				end
				uart_pkg::RX_STOP: begin
					if (sample_now)
						state <= uart_pkg::RX_IDLE; // next edge can start a frame right away
					else
						sample_cnt <= sample_cnt - 1'b1;
				end
				default: state <= uart_pkg::RX_IDLE;
			endcase
		end
	end

	// data shift register, lsb arrives first so shift right
	always_ff @(posedge clk) begin
		if (state == uart_pkg::RX_DATA && sample_now)
			shift_q <= {rxd_sync, shift_q[7:1]};
	end

	// --------------------
	// outputs
	// --------------------

	// stop bit is checked live, so the frame goes out in the sampling cycle
	assign frame_valid     = (state == uart_pkg::RX_STOP) && sample_now;
	assign frame.data      = shift_q;
	assign frame.frame_err = ~rxd_sync; // low stop bit is a framing error

	assign rx_busy = (state != uart_pkg::RX_IDLE); // drops right after the stop sample

endmodule

//--- source/uart_rx_top.sv
`timescale 1ns/10ps

module uart_rx_top (
	input  logic              clk,
	input  logic              nrst,
	input  logic              rxd,    // serial in, idles high
	input  uart_pkg::wb_req_t wb_req,
	output uart_pkg::wb_rsp_t wb_rsp
);

	// --------------------
	// internal nets
	// --------------------

	uart_pkg::rx_frame_t frame;       // receiver to fifo
	logic                frame_valid;
	logic                rx_busy;
	uart_pkg::rx_frame_t head;        // fifo to registers
	logic                empty;
	logic                full;
	logic                overrun;
	logic                pop;         // registers back to fifo
	logic                overrun_clr;

	uart_receiver u_receiver (
		.clk         (clk),
		.nrst        (nrst),
		.rxd         (rxd),
		.frame       (frame),
		.frame_valid (frame_valid),
		.rx_busy     (rx_busy)
	);

	rx_fifo u_fifo (
		.clk         (clk),
		.nrst        (nrst),
		.push_frame  (frame),
		.push        (frame_valid), // no stall path to the line
		.pop         (pop),
		.overrun_clr (overrun_clr),
		.head        (head),
		.empty       (empty),
		.full        (full),
		.overrun     (overrun)
	);

	wb_uart_regs u_regs (
		.clk         (clk),
		.nrst        (nrst),
		.wb_req      (wb_req),
		.wb_rsp      (wb_rsp),
		.head        (head),
		.empty       (empty),
		.full        (full),
		.overrun     (overrun),
		.rx_busy     (rx_busy),
		.pop         (pop),
		.overrun_clr (overrun_clr)
	);

endmodule

//--- source/wb_uart_regs.sv
`timescale 1ns/10ps

module wb_uart_regs (
	input  logic                clk,
	input  logic                nrst,
	input  uart_pkg::wb_req_t   wb_req,
	output uart_pkg::wb_rsp_t   wb_rsp,
	input  uart_pkg::rx_frame_t head,
	input  logic                empty,
	input  logic                full,
	input  logic                overrun,
	input  logic                rx_busy,
	output logic                pop,         // one clk, same cycle as ack
	output logic                overrun_clr  // one clk, same cycle as ack
);

	// --------------------
	// request detect
	// --------------------

	logic                new_req; // first cycle of a transfer
	logic                ack_q;
	logic [7:0]          dat_q;
	logic [7:0]          status;
	logic [7:0]          rd_mux;
	uart_pkg::wb_reg_e   reg_sel;

	// ack is still high while the master holds stb, so that cycle is not new
	assign new_req = wb_req.cyc & wb_req.stb & ~ack_q;
	assign reg_sel = uart_pkg::wb_reg_e'(wb_req.adr);

	// --------------------
	// read data
	// --------------------

	always_comb begin
		status                       = '0;
		status[uart_pkg::STAT_EMPTY] = empty;
		status[uart_pkg::STAT_FULL]  = full;
		status[uart_pkg::STAT_FERR]  = head.frame_err & ~empty; // head is stale when empty
		status[uart_pkg::STAT_OVR]   = overrun;
		status[uart_pkg::STAT_BUSY]  = rx_busy;
	end

	always_comb begin
		case (reg_sel)
			uart_pkg::REG_DATA:   rd_mux = empty ? 8'h00 : head.data;
			uart_pkg::REG_STATUS: rd_mux = status;
			default:              rd_mux = 8'h00; // ctrl is write only, index 3 unused
		endcase
	end

	// --------------------
	// ack and strobes
	// --------------------

	always_ff @(posedge clk) begin
		if (!nrst) begin
			ack_q       <= 1'b0;
			pop         <= 1'b0;
			overrun_clr <= 1'b0;
		end else begin
			ack_q <= new_req; // exactly one cycle later, one cycle wide
			pop   <= new_req & ~wb_req.we & (reg_sel == uart_pkg::REG_DATA) & ~empty;
			overrun_clr <= new_req & wb_req.we & (reg_sel == uart_pkg::REG_CTRL) &
				wb_req.dat_w[uart_pkg::STAT_OVR];
		end
	end

	// read data captured with the request, so status is the pre-ack view
	always_ff @(posedge clk) begin
		if (new_req)
			dat_q <= wb_req.we ? 8'h00 : rd_mux;
	end

	assign wb_rsp.ack   = ack_q;
	assign wb_rsp.dat_r = dat_q;

endmodule

//--- sources.f
source/uart_pkg.sv
source/uart_receiver.sv
source/rx_fifo.sv
source/wb_uart_regs.sv
source/uart_rx_top.sv
test/uart_rx_assertions.sv
test/tb_uart_rx.sv

//--- test/tb_uart_rx.sv
`timescale 1ns/10ps

module tb_uart_rx;

	localparam int N_ROWS    = 6;
	localparam int ACK_LIMIT = 8; // cycles to wait for a bus ack

	// one stimulus row, bytes and stop levels are indexed from 0
	typedef struct packed {
		logic [2:0]      name_idx;
		logic [3:0]      count;    // frames sent
		logic [0:8][7:0] data;
		logic [0:8]      stop;     // stop bit level per frame
		logic            gap;      // idle bit between frames
		logic            drain;    // read everything back after sending
		logic [7:0]      exp_stat; // status right after the last frame
	} test_row_t;

	logic                clk;
	logic                nrst;
	logic                rxd;
	uart_pkg::wb_req_t   wb_req;
	uart_pkg::wb_rsp_t   wb_rsp;
	test_row_t           rows [N_ROWS];
	string               test_names [N_ROWS];
	int                  errors;       // in the current test
	int                  tests_passed;
	int                  tests_failed;
	int                  cycles;
	int                  cycle_limit;
	int                  seed;

	uart_rx_top dut (.clk(clk), .nrst(nrst), .rxd(rxd), .wb_req(wb_req), .wb_rsp(wb_rsp));

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// run limit, armed once the table length is known
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycle_limit != 0 && cycles >= cycle_limit) begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	// --------------------
	// helpers
	// --------------------

	function automatic logic [7:0] status_bits(input logic e, input logic f,
		input logic fe, input logic ov);
		logic [7:0] s;
		s                       = 8'h00;
		s[uart_pkg::STAT_EMPTY] = e;
		s[uart_pkg::STAT_FULL]  = f;
		s[uart_pkg::STAT_FERR]  = fe;
		s[uart_pkg::STAT_OVR]   = ov;
		return s; // busy is expected low whenever status is read
	endfunction

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got 0x%02h, expected 0x%02h", name, got, exp);
			errors++;
		end
	endtask

	// caller sits on a rising edge, one serial bit per call
	task automatic drive_bit(input logic level);
		rxd <= level;
		repeat (uart_pkg::BIT_CLKS) @(posedge clk);
	endtask

	task automatic send_frame(input logic [7:0] data, input logic stop_bit, input logic idle);
		drive_bit(1'b0); // start bit
		for (int b = 0; b < 8; b++)
			drive_bit(data[b]); // lsb first
		drive_bit(stop_bit);
		if (idle || !stop_bit)
			drive_bit(1'b1); // a low stop needs a high bit before the next start edge
	endtask

	// single wishbone classic transfer, ack sampled on the falling edge
	task automatic bus_transfer(input logic we, input logic [1:0] adr,
		input logic [7:0] wdata, output logic [7:0] rdata);
		int waited;
		waited = 0;
		@(posedge clk);
		wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat_w: wdata};
		@(negedge clk);
		while (!wb_rsp.ack && waited < ACK_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (!wb_rsp.ack) begin
			$display("bus transfer to register %0d got no ack", adr);
			errors++;
		end
		rdata = wb_rsp.dat_r;
		@(posedge clk);
		wb_req <= '0; // stb drops the cycle after ack
	endtask

	// --------------------
	// stimulus table and main loop
	// --------------------

	initial begin
		logic [7:0] rd;
		logic [7:0] exp_st;
		int         rnd;
		int         nframes;
		int         nread;
		int         total;
		rxd          = 1'b1;
		nrst         = 1'b0;
		wb_req       = '0;
		errors       = 0;
		tests_passed = 0;
		tests_failed = 0;
		cycles       = 0;
		cycle_limit  = 0;
		seed         = 98715;
		test_names   = '{"in order", "framing error", "back to back", "overrun",
			"empty and unused", "random bytes"};
		rows[0] = '{name_idx: 3'd0, count: 4'd3, data: {8'h55, 8'hA3, 8'h0F, 48'h0},
			stop: 9'h1FF, gap: 1'b1, drain: 1'b1, exp_stat: status_bits(0, 0, 0, 0)};
		rows[1] = '{name_idx: 3'd1, count: 4'd2, data: {8'hA5, 8'h3C, 56'h0},
			stop: 9'b0_1111_1111, gap: 1'b0, drain: 1'b1, exp_stat: status_bits(0, 0, 1, 0)};
		rows[2] = '{name_idx: 3'd2, count: 4'd4, data: {8'h00, 8'hFF, 8'h81, 8'h7E, 40'h0},
			stop: 9'h1FF, gap: 1'b0, drain: 1'b1, exp_stat: status_bits(0, 0, 0, 0)};
		rows[3] = '{name_idx: 3'd3, count: 4'd9,
			data: {8'h01, 8'h02, 8'h03, 8'h04, 8'h05, 8'h06, 8'h07, 8'h08, 8'h09},
			stop: 9'h1FF, gap: 1'b0, drain: 1'b1, exp_stat: status_bits(0, 1, 0, 1)};
		rows[4] = '{name_idx: 3'd4, count: 4'd0, data: '0,
			stop: 9'h1FF, gap: 1'b0, drain: 1'b1, exp_stat: status_bits(1, 0, 0, 0)};
		rows[5] = '{name_idx: 3'd5, count: 4'd8, data: '0,
			stop: 9'h1FF, gap: 1'b0, drain: 1'b1, exp_stat: status_bits(0, 1, 0, 0)};
		for (int i = 0; i < 8; i++) begin
			rnd = $random(seed);
			rows[5].data[i] = rnd[7:0];
		end

		// frames plus idle bits, bus reads and margin
		total = 0;
		for (int r = 0; r < N_ROWS; r++)
			total += int'(rows[r].count);
		cycle_limit = 500 + total * (11 * uart_pkg::BIT_CLKS + 40) + N_ROWS * 100;

		repeat (16) @(posedge clk);
		nrst <= 1'b1;
		drive_bit(1'b1);

		for (int r = 0; r < N_ROWS; r++) begin
			errors  = 0;
			nframes = int'(rows[r].count);
			for (int i = 0; i < nframes; i++)
				send_frame(rows[r].data[i], rows[r].stop[i], rows[r].gap);
			bus_transfer(1'b0, uart_pkg::REG_STATUS, 8'h00, rd);
			check_byte("status", rd, rows[r].exp_stat);
			if (rows[r].drain) begin
				nread = (nframes > uart_pkg::FIFO_DEPTH) ? uart_pkg::FIFO_DEPTH : nframes;
				for (int i = 0; i < nread; i++) begin
					bus_transfer(1'b0, uart_pkg::REG_STATUS, 8'h00, rd);
					check_byte("status.ferr", {7'b0, rd[uart_pkg::STAT_FERR]},
						{7'b0, ~rows[r].stop[i]});
					bus_transfer(1'b0, uart_pkg::REG_DATA, 8'h00, rd);
					check_byte("dat_r", rd, rows[r].data[i]); // ninth byte never shows up
				end
				exp_st = status_bits(1, 0, 0, nframes > uart_pkg::FIFO_DEPTH);
				bus_transfer(1'b0, uart_pkg::REG_STATUS, 8'h00, rd);
				check_byte("status after drain", rd, exp_st);
				bus_transfer(1'b0, uart_pkg::REG_DATA, 8'h00, rd);
				check_byte("dat_r when empty", rd, 8'h00);
				bus_transfer(1'b0, 2'd3, 8'h00, rd);
				check_byte("dat_r unused address", rd, 8'h00);
				bus_transfer(1'b1, uart_pkg::REG_CTRL, 8'h08, rd); // clear overrun
				bus_transfer(1'b0, uart_pkg::REG_STATUS, 8'h00, rd);
				check_byte("status after clear", rd, status_bits(1, 0, 0, 0));
			end
			if (errors == 0) begin
				$display("test %0d %s: ok", r + 1, test_names[rows[r].name_idx]);
				tests_passed++;
			end else begin
				$display("test %0d %s: %0d errors", r + 1, test_names[rows[r].name_idx],
					errors);
				tests_failed++;
			end
		end

		if (dut.u_assert.fail_cnt != 0) begin
			$display("%0d assertion failures during the run", dut.u_assert.fail_cnt);
			tests_failed++;
		end
		$display("tests passed %0d, failed %0d", tests_passed, tests_failed);
		if (tests_failed == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

//--- test/uart_rx_assertions.sv
`timescale 1ns/10ps

module uart_rx_assertions (
	input logic              clk,
	input logic              nrst,
	input uart_pkg::wb_req_t wb_req,
	input uart_pkg::wb_rsp_t wb_rsp,
	input logic              frame_valid, // receiver strobe into the fifo
	input logic              rx_busy
);

	int fail_cnt = 0; // read back by the testbench at the end

	// --------------------
	// bus rules
	// --------------------

	ack_one_cycle: assert property (@(posedge clk) disable iff (!nrst)
		wb_rsp.ack |=> !wb_rsp.ack)
	else begin
		$error("ack stayed high for two cycles");
		fail_cnt++;
	end

	// ack only answers a request seen the cycle before
	ack_after_req: assert property (@(posedge clk) disable iff (!nrst)
		wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb))
	else begin
		$error("ack without a cyc and stb request");
		fail_cnt++;
	end

	// --------------------
	// receiver rules
	// --------------------

	// busy must have held for the whole 9.5 bit frame before frame_valid
	valid_while_busy: assert property (@(posedge clk) disable iff (!nrst)
		frame_valid |-> rx_busy &&
			$past(rx_busy, 9 * uart_pkg::BIT_CLKS + uart_pkg::HALF_BIT_CLKS - 1))
	else begin
		$error("frame_valid outside a frame");
		fail_cnt++;
	end

endmodule

bind uart_rx_top uart_rx_assertions u_assert (
	.clk         (clk),
	.nrst        (nrst),
	.wb_req      (wb_req),
	.wb_rsp      (wb_rsp),
	.frame_valid (frame_valid),
	.rx_busy     (rx_busy)
);
